//--- tb.f
+incdir+design
design/node_pkg.sv
design/cache_pkg.sv
design/op_decode.sv
design/cache_exec.sv
design/mock_memory.sv
design/result_format.sv
design/test_node_client.sv
tests/test_node_client_sva.sv
tests/tb_test_node_client.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_test_node_client -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "^SIMULATION PASSED$" sim.log \
  && echo "run.sh: test run passed" \
  || { echo "run.sh: test run failed"; exit 1; }

//--- tests/tb_test_node_client.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module tb_test_node_client
  import node_pkg::*;
();

  localparam int MEM_AW = $clog2(`MEM_WORDS);
  localparam int DIRECTED_OPS = 27;
  localparam int BP_OPS = 40;
  localparam int RAND_OPS = 300;
  localparam int TOTAL_OPS = DIRECTED_OPS + BP_OPS + RAND_OPS;
  localparam int BUDGET = TOTAL_OPS * (`MEM_LATENCY + 2 * `BLOCK_WORDS + 10) * 2;

  logic clock_i;
  logic rst_i;
  logic v_i;
  logic [PKT_W-1:0] data_i;
  logic ready_o;
  logic v_o;
  logic [PKT_W-1:0] data_o;
  logic yumi_i;

  logic [31:0] ref_mem [`MEM_WORDS];
  logic [PKT_W-1:0] exp_q [$];
  string name_q [$];
  logic [PKT_W-1:0] exp_data;
  string exp_name;
  string test_name;
  logic [31:0] stim_rng;
  logic [31:0] yumi_rng;
  logic stall_en;
  int sent_count;
  int recv_count;
  int mismatch_errors;
  int other_errors;

  test_node_client u_test_node_client (
    .clock_i(clock_i)
    ,.rst_i(rst_i)
    ,.v_i(v_i)
    ,.data_i(data_i)
    ,.ready_o(ready_o)
    ,.v_o(v_o)
    ,.data_o(data_o)
    ,.yumi_i(yumi_i)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [PKT_W-1:0] make_pkt(input logic [3:0] instr, input logic [1:0] size,
      input logic sigext, input logic [31:0] addr, input logic [31:0] data);
    logic [PKT_W-1:0] pkt;
    pkt = '0;
    pkt[SIGEXT_BIT] = sigext;
    pkt[SIZE_LSB +: SIZE_W] = size;
    pkt[INSTR_LSB +: INSTR_W] = instr;
    pkt[ADDR_LSB +: ADDR_W] = addr;
    pkt[DATA_LSB +: DATA_W] = data;
    return pkt;
  endfunction

  // applies one command to the model memory and returns the expected response.
  function automatic logic [PKT_W-1:0] ref_access(input logic [PKT_W-1:0] pkt);
    logic sigext;
    logic [1:0] size;
    logic [3:0] instr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [MEM_AW-1:0] widx;
    logic [31:0] word;
    logic [7:0] lane8;
    logic [15:0] lane16;
    logic [31:0] result;
    sigext = pkt[SIGEXT_BIT];
    size = pkt[SIZE_LSB +: SIZE_W];
    instr = pkt[INSTR_LSB +: INSTR_W];
    addr = pkt[ADDR_LSB +: ADDR_W];
    wdata = pkt[DATA_LSB +: DATA_W];
    widx = addr[2 +: MEM_AW]; // byte address wraps at the memory size.
    word = ref_mem[widx];
    result = '0;
    if (instr == OP_STORE) begin
      case (size)
        2'd0: word[8 * addr[1:0] +: 8] = wdata[7:0];
        2'd1: word[16 * addr[1] +: 16] = wdata[15:0];
        default: word = wdata;
      endcase
      ref_mem[widx] = word;
    end else if (instr == OP_LOAD) begin
      lane8 = word[8 * addr[1:0] +: 8];
      lane16 = word[16 * addr[1] +: 16];
      case (size)
        2'd0: result = {{24{sigext & lane8[7]}}, lane8};
        2'd1: result = {{16{sigext & lane16[15]}}, lane16};
        default: result = word;
      endcase
    end
    return {{RESP_PAD_W{1'b0}}, result};
  endfunction

  // called on a falling edge, returns on the falling edge after acceptance.
  task automatic send_pkt(input logic [PKT_W-1:0] pkt);
    v_i = 1'b1;
    data_i = pkt;
    @(posedge clock_i);
    while (!ready_o) @(posedge clock_i);
    exp_q.push_back(ref_access(pkt));
    name_q.push_back(test_name);
    sent_count++;
    @(negedge clock_i);
    v_i = 1'b0;
  endtask

  task automatic run_random(input int count);
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] addr;
    logic [3:0] instr;
    for (int i = 0; i < count; i++) begin
      stim_rng = xorshift(stim_rng);
      r = stim_rng;
      stim_rng = xorshift(stim_rng);
      d = stim_rng;
      addr = {21'b0, r[10:0]}; // 2 KiB window, many tags per set.
      if (r[31:29] == 3'd0) addr[31:14] = d[31:14];
      if (r[13:11] < 3'd3) instr = OP_LOAD;
      else if (r[13:11] < 3'd6) instr = OP_STORE;
      else instr = r[27:24] | 4'h2; // no-op opcode.
      send_pkt(make_pkt(instr, r[15:14], r[16], addr, d));
    end
  endtask

  initial begin
    clock_i = 1'b0;
    forever #20 clock_i = ~clock_i;
  end

  // yumi follows v_o, with random holds while stalling is on.
  initial begin
    yumi_i = 1'b0;
    yumi_rng = 32'd30159;
    forever begin
      @(negedge clock_i);
      yumi_rng = xorshift(yumi_rng);
      yumi_i = v_o && (!stall_en || (yumi_rng[2:0] > 3'd2));
    end
  end

  always @(posedge clock_i) begin
    if (!rst_i && v_o && yumi_i) begin
      recv_count++;
      if (exp_q.size() == 0) begin
        $display("a response came out with no command outstanding at %0t", $time);
        other_errors++;
      end else begin
        exp_data = exp_q.pop_front();
        exp_name = name_q.pop_front();
        if (data_o !== exp_data) begin
          $display("ERROR %s: expected %h actual %h", exp_name, exp_data, data_o);
          mismatch_errors++;
        end
      end
    end
  end

  initial begin
    repeat (BUDGET) @(posedge clock_i);
    $display("timeout: the DUT did not finish within %0d cycles and seems hung", BUDGET);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    v_i = 1'b0;
    data_i = '0;
    rst_i = 1'b1;
    stall_en = 1'b0;
    stim_rng = 32'd30159;
    sent_count = 0;
    recv_count = 0;
    mismatch_errors = 0;
    other_errors = 0;
    for (int w = 0; w < `MEM_WORDS; w++) begin
      ref_mem[w] = `MEM_FILL_BASE + 32'(w);
    end
    repeat (4) @(posedge clock_i);
    @(negedge clock_i);
    if (ready_o !== 1'b0) begin
      $display("ready_o is high while reset is asserted");
      other_errors++;
    end
    rst_i = 1'b0;
    if (v_o !== 1'b0) begin
      $display("v_o is high right after reset");
      other_errors++;
    end

    test_name = "reset_fill";
    send_pkt(make_pkt(OP_LOAD, SZ_WORD, 1'b0, 32'h0000_0000, 32'h0));
    send_pkt(make_pkt(OP_LOAD, SZ_WORD, 1'b0, 32'h0000_0104, 32'h0));
    send_pkt(make_pkt(OP_LOAD, SZ_WORD, 1'b0, 32'h0000_2ff8, 32'h0));
    send_pkt(make_pkt(OP_LOAD, SZ_WORD, 1'b0, 32'h0001_3ffc, 32'h0)); // wraps to the top word.

    test_name = "store_load";
    send_pkt(make_pkt(OP_STORE, SZ_WORD, 1'b0, 32'h0000_0040, 32'hdead_beef));
    send_pkt(make_pkt(OP_LOAD, SZ_WORD, 1'b0, 32'h0000_0040, 32'h0));
    send_pkt(make_pkt(OP_LOAD, SZ_WORD, 1'b0, 32'h0000_0042, 32'h0));

    test_name = "lanes";
    send_pkt(make_pkt(OP_STORE, SZ_WORD, 1'b0, 32'h0000_0080, 32'h7091_a2b3));
    send_pkt(make_pkt(OP_STORE, SZ_BYTE, 1'b0, 32'h0000_0081, 32'h0000_00f5));
    send_pkt(make_pkt(OP_STORE, SZ_HALF, 1'b0, 32'h0000_0086, 32'h0000_7c01));
    for (int b = 0; b < 4; b++) begin
      for (int s = 0; s < 2; s++) begin
        send_pkt(make_pkt(OP_LOAD, SZ_BYTE, s[0], 32'h80 + b, 32'h0));
      end
    end
    for (int h = 0; h < 2; h++) begin
      for (int s = 0; s < 2; s++) begin
        send_pkt(make_pkt(OP_LOAD, SZ_HALF, s[0], 32'h80 + 3 * h, 32'h0));
      end
    end
    send_pkt(make_pkt(OP_LOAD, SZ_WORD, 1'b1, 32'h0000_0085, 32'h0));

    // same set, different tags, so both dirty lines get written back and refilled.
    test_name = "eviction";
    send_pkt(make_pkt(OP_STORE, SZ_WORD, 1'b0, 32'h0000_0300, 32'ha5a5_0300));
    send_pkt(make_pkt(OP_STORE, SZ_WORD, 1'b0, 32'h0000_0400, 32'h5a5a_0400));
    send_pkt(make_pkt(OP_LOAD, SZ_WORD, 1'b0, 32'h0000_0300, 32'h0));
    send_pkt(make_pkt(OP_LOAD, SZ_WORD, 1'b0, 32'h0000_0400, 32'h0));

    test_name = "backpressure";
    @(posedge clock_i);
    stall_en = 1'b1;
    @(negedge clock_i);
    run_random(BP_OPS);
    while (exp_q.size() != 0) @(posedge clock_i);
    stall_en = 1'b0;
    @(negedge clock_i);

    test_name = "random_mix";
    run_random(RAND_OPS);
    while (exp_q.size() != 0) @(posedge clock_i);
    repeat (10) @(posedge clock_i); // a duplicate response would show up here.
    if (recv_count != sent_count) begin
      $display("sent %0d commands but got %0d responses", sent_count, recv_count);
      other_errors++;
    end

    $display("errors: %0d value mismatches, %0d other failures", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- tests/test_node_client_sva.sv
`timescale 1ns/1ns

module test_node_client_sva
  import node_pkg::*;
(
  input clock_i
  ,input rst_i
  ,input resp_v_i
  ,input [PKT_W-1:0] resp_data_i
  ,input yumi_i
  ,input dma_req_v_i
  ,input dma_req_yumi_i
);

  resp_hold: assert property (@(posedge clock_i) disable iff (rst_i)
    resp_v_i && !yumi_i |=> resp_v_i && $stable(resp_data_i))
    else $error("response dropped or changed before yumi_i");

  dma_req_hold: assert property (@(posedge clock_i) disable iff (rst_i)
    dma_req_v_i && !dma_req_yumi_i |=> dma_req_v_i)
    else $error("dma request withdrawn before it was taken");

  resp_quiet_in_reset: assert property (@(posedge clock_i)
    rst_i |=> !resp_v_i)
    else $error("response valid while in reset");

  yumi_needs_valid: assert property (@(posedge clock_i)
    yumi_i |-> resp_v_i)
    else $error("yumi_i raised without a valid response");

endmodule

bind test_node_client test_node_client_sva u_test_node_client_sva (
  .clock_i(clock_i)
  ,.rst_i(rst_i)
  ,.resp_v_i(v_o)
  ,.resp_data_i(data_o)
  ,.yumi_i(yumi_i)
  ,.dma_req_v_i(dma_req_v)
  ,.dma_req_yumi_i(dma_req_yumi)
);

//--- design/test_node_client.sv
`timescale 1ns/1ns

module test_node_client
  import node_pkg::*;
(
  input clock_i
  ,input rst_i
  ,input v_i
  ,input [PKT_W-1:0] data_i
  ,output logic ready_o
  ,output logic v_o
  ,output logic [PKT_W-1:0] data_o
  ,input yumi_i
);

  logic dec_v;
  logic dec_ready;
  instr_e dec_instr;
  size_e dec_size;
  logic dec_sigext;
  logic [31:0] dec_addr;
  logic [31:0] dec_data;

  logic ex_v;
  logic ex_ready;
  logic [31:0] ex_word;
  logic [1:0] ex_byte_off;
  size_e ex_size;
  logic ex_sigext;

  logic dma_req_v;
  logic dma_req_write_not_read;
  logic [31:0] dma_req_addr;
  logic dma_req_yumi;
  logic dma_read_v;
  logic [31:0] dma_read_data;
  logic dma_read_ready;
  logic dma_write_v;
  logic [31:0] dma_write_data;
  logic dma_write_yumi;

  op_decode u_op_decode (
    .clock_i(clock_i)
    ,.rst_i(rst_i)
    ,.v_i(v_i)
    ,.data_i(data_i)
    ,.ready_o(ready_o)
    ,.dec_v_o(dec_v)
    ,.dec_ready_i(dec_ready)
    ,.dec_instr_o(dec_instr)
    ,.dec_size_o(dec_size)
    ,.dec_sigext_o(dec_sigext)
    ,.dec_addr_o(dec_addr)
    ,.dec_data_o(dec_data)
  );

  cache_exec u_cache_exec (
    .clock_i(clock_i)
    ,.rst_i(rst_i)
    ,.dec_v_i(dec_v)
    ,.dec_ready_o(dec_ready)
    ,.dec_instr_i(dec_instr)
    ,.dec_size_i(dec_size)
    ,.dec_sigext_i(dec_sigext)
    ,.dec_addr_i(dec_addr)
    ,.dec_data_i(dec_data)
    ,.ex_v_o(ex_v)
    ,.ex_ready_i(ex_ready)
    ,.ex_word_o(ex_word)
    ,.ex_byte_off_o(ex_byte_off)
    ,.ex_size_o(ex_size)
    ,.ex_sigext_o(ex_sigext)
    ,.dma_req_v_o(dma_req_v)
    ,.dma_req_write_not_read_o(dma_req_write_not_read)
    ,.dma_req_addr_o(dma_req_addr)
    ,.dma_req_yumi_i(dma_req_yumi)
    ,.dma_read_v_i(dma_read_v)
    ,.dma_read_data_i(dma_read_data)
    ,.dma_read_ready_o(dma_read_ready)
    ,.dma_write_v_o(dma_write_v)
    ,.dma_write_data_o(dma_write_data)
    ,.dma_write_yumi_i(dma_write_yumi)
  );

  result_format u_result_format (
    .clock_i(clock_i)
    ,.rst_i(rst_i)
    ,.ex_v_i(ex_v)
    ,.ex_ready_o(ex_ready)
    ,.ex_word_i(ex_word)
    ,.ex_byte_off_i(ex_byte_off)
    ,.ex_size_i(ex_size)
    ,.ex_sigext_i(ex_sigext)
    ,.v_o(v_o)
    ,.data_o(data_o)
    ,.yumi_i(yumi_i)
  );

  mock_memory u_mock_memory (
    .clock_i(clock_i)
    ,.rst_i(rst_i)
    ,.dma_req_v_i(dma_req_v)
    ,.dma_req_write_not_read_i(dma_req_write_not_read)
    ,.dma_req_addr_i(dma_req_addr)
    ,.dma_req_yumi_o(dma_req_yumi)
    ,.dma_read_v_o(dma_read_v)
    ,.dma_read_data_o(dma_read_data)
    ,.dma_read_ready_i(dma_read_ready)
    ,.dma_write_v_i(dma_write_v)
    ,.dma_write_data_i(dma_write_data)
    ,.dma_write_yumi_o(dma_write_yumi)
  );

endmodule

//--- design/result_format.sv
`timescale 1ns/1ns

module result_format
  import node_pkg::*;
(
  input clock_i
  ,input rst_i
  ,input ex_v_i
  ,output logic ex_ready_o
  ,input [31:0] ex_word_i
  ,input [1:0] ex_byte_off_i
  ,input size_e ex_size_i
  ,input ex_sigext_i
  ,output logic v_o
  ,output logic [PKT_W-1:0] data_o
  ,input yumi_i
);

  logic [7:0] lane_b;
  logic [15:0] lane_h;
  logic [31:0] ext;

  assign lane_b = ex_word_i[{ex_byte_off_i, 3'b000} +: 8];
  assign lane_h = ex_word_i[{ex_byte_off_i[1], 4'b0000} +: 16];

  always_comb begin
    case (ex_size_i)
      SZ_BYTE: ext = {{24{ex_sigext_i & lane_b[7]}}, lane_b};
      SZ_HALF: ext = {{16{ex_sigext_i & lane_h[15]}}, lane_h};
      default: ext = ex_word_i;
    endcase
  end

  assign ex_ready_o = !v_o || yumi_i; // slot free or leaving this cycle.

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      v_o <= 1'b0;
    end else if (ex_v_i && ex_ready_o) begin
      v_o <= 1'b1;
    end else if (yumi_i) begin
      v_o <= 1'b0;
    end
  end

  always_ff @(posedge clock_i) begin
    if (ex_v_i && ex_ready_o) begin
      data_o <= {{RESP_PAD_W{1'b0}}, ext};
    end
  end

endmodule

//--- design/mock_memory.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module mock_memory
  import cache_pkg::*;
(
  input clock_i
  ,input rst_i
  ,input dma_req_v_i
  ,input dma_req_write_not_read_i
  ,input [31:0] dma_req_addr_i
  ,output logic dma_req_yumi_o
  ,output logic dma_read_v_o
  ,output logic [31:0] dma_read_data_o
  ,input dma_read_ready_i
  ,input dma_write_v_i
  ,input [31:0] dma_write_data_i
  ,output logic dma_write_yumi_o
);

  localparam int MEM_AW = $clog2(`MEM_WORDS);
  localparam int LAT_W = $clog2(`MEM_LATENCY + 1);
  localparam logic [1:0] M_IDLE = 2'd0;
  localparam logic [1:0] M_WAIT = 2'd1;
  localparam logic [1:0] M_READ = 2'd2;
  localparam logic [1:0] M_WRITE = 2'd3;

  logic [1:0] state_r;
  logic write_r;
  logic [MEM_AW-1:0] base_r;
  logic [WOFF_W-1:0] beat_r;
  logic [LAT_W-1:0] wait_r;
  logic [31:0] mem_r [`MEM_WORDS];
  cache_addr_u req_a;
  logic [MEM_AW-1:0] word_addr;
  logic last_beat;

  assign req_a = dma_req_addr_i;
  assign word_addr = base_r + MEM_AW'(beat_r);
  assign last_beat = (beat_r == WOFF_W'(`BLOCK_WORDS - 1));

  assign dma_req_yumi_o = (state_r == M_IDLE) && dma_req_v_i;
  assign dma_read_v_o = (state_r == M_READ);
  assign dma_read_data_o = mem_r[word_addr];
  assign dma_write_yumi_o = (state_r == M_WRITE) && dma_write_v_i;

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      state_r <= M_IDLE;
      beat_r <= '0;
      wait_r <= '0;
      for (int w = 0; w < `MEM_WORDS; w++) begin
        mem_r[w] <= `MEM_FILL_BASE + 32'(w);
      end
    end else begin
      case (state_r)
        M_IDLE: begin
          if (dma_req_yumi_o) begin
            state_r <= M_WAIT;
            write_r <= dma_req_write_not_read_i;
            base_r <= {req_a.flat[MEM_AW+1:2+WOFF_W], WOFF_W'(0)}; // high bits wrap.
            beat_r <= '0;
            wait_r <= '0;
          end
        end
        M_WAIT: begin
          if (wait_r == LAT_W'(`MEM_LATENCY - 1)) begin
            state_r <= write_r ? M_WRITE : M_READ;
          end else begin
            wait_r <= wait_r + 1'b1;
          end
        end
        M_READ: begin
          if (dma_read_ready_i) begin
            beat_r <= beat_r + 1'b1;
            if (last_beat) state_r <= M_IDLE;
          end
        end
        default: begin
          if (dma_write_yumi_o) begin
            mem_r[word_addr] <= dma_write_data_i;
            beat_r <= beat_r + 1'b1;
            if (last_beat) state_r <= M_IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- design/cache_exec.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cache_exec
  import node_pkg::*, cache_pkg::*;
(
  input clock_i
  ,input rst_i
  ,input dec_v_i
  ,output logic dec_ready_o
  ,input instr_e dec_instr_i
  ,input size_e dec_size_i
  ,input dec_sigext_i
  ,input [31:0] dec_addr_i
  ,input [31:0] dec_data_i
  ,output logic ex_v_o
  ,input ex_ready_i
  ,output logic [31:0] ex_word_o
  ,output logic [1:0] ex_byte_off_o
  ,output size_e ex_size_o
  ,output logic ex_sigext_o
  ,output logic dma_req_v_o
  ,output logic dma_req_write_not_read_o
  ,output logic [31:0] dma_req_addr_o
  ,input dma_req_yumi_i
  ,input dma_read_v_i
  ,input [31:0] dma_read_data_i
  ,output logic dma_read_ready_o
  ,output logic dma_write_v_o
  ,output logic [31:0] dma_write_data_o
  ,input dma_write_yumi_i
);

  localparam logic [2:0] S_IDLE = 3'd0;
  localparam logic [2:0] S_WB_REQ = 3'd1;
  localparam logic [2:0] S_WB_DATA = 3'd2;
  localparam logic [2:0] S_FILL_REQ = 3'd3;
  localparam logic [2:0] S_FILL_DATA = 3'd4;
  localparam logic [2:0] S_DONE = 3'd5;

  logic [2:0] state_r;
  line_state_s tags_r [`CACHE_SETS];
  logic [31:0] data_r [`CACHE_SETS][`BLOCK_WORDS];
  instr_e op_instr_r;
  size_e op_size_r;
  logic op_sigext_r;
  logic [31:0] op_addr_r;
  logic [31:0] op_data_r;
  logic [WOFF_W-1:0] beat_r;

  instr_e cur_instr;
  size_e cur_size;
  logic cur_sigext;
  cache_addr_u cur_a;
  logic [31:0] cur_data;
  line_state_s cur_line;
  cache_addr_u req_a;
  logic [3:0] be;
  logic [31:0] merged;
  logic out_free;
  logic is_mem;
  logic hit;
  logic go;
  logic do_op;
  logic last_beat;

  // idle works on the incoming op, every other state on the latched miss.
  always_comb begin
    if (state_r == S_IDLE) begin
      cur_instr = dec_instr_i;
      cur_size = dec_size_i;
      cur_sigext = dec_sigext_i;
      cur_a = dec_addr_i;
      cur_data = dec_data_i;
    end else begin
      cur_instr = op_instr_r;
      cur_size = op_size_r;
      cur_sigext = op_sigext_r;
      cur_a = op_addr_r;
      cur_data = op_data_r;
    end
  end

  assign cur_line = tags_r[cur_a.f.index];
  assign out_free = !ex_v_o || ex_ready_i;
  assign dec_ready_o = (state_r == S_IDLE) && out_free;
  assign is_mem = (cur_instr == OP_LOAD) || (cur_instr == OP_STORE);
  assign hit = cur_line.valid && (cur_line.tag == cur_a.f.tag);
  assign go = (state_r == S_IDLE) ? (dec_v_i && out_free) : ((state_r == S_DONE) && out_free);
  assign do_op = go && (!is_mem || hit); // always a hit in S_DONE.
  assign last_beat = (beat_r == WOFF_W'(`BLOCK_WORDS - 1));

  always_comb begin
    case (cur_size)
      SZ_BYTE: be = 4'b0001 << cur_a.f.byte_off;
      SZ_HALF: be = 4'b0011 << cur_a.f.byte_off;
      default: be = 4'b1111;
    endcase
    merged = data_r[cur_a.f.index][cur_a.f.word_off];
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        merged[8*i +: 8] = cur_data[8*i +: 8];
      end
    end
  end

  // block address of the victim or of the line being filled.
  always_comb begin
    req_a.flat = '0;
    req_a.f.index = cur_a.f.index;
    req_a.f.tag = (state_r == S_WB_REQ) ? cur_line.tag : cur_a.f.tag;
  end

  assign dma_req_v_o = (state_r == S_WB_REQ) || (state_r == S_FILL_REQ);
  assign dma_req_write_not_read_o = (state_r == S_WB_REQ);
  assign dma_req_addr_o = req_a.flat;
  assign dma_write_v_o = (state_r == S_WB_DATA);
  assign dma_write_data_o = data_r[cur_a.f.index][beat_r];
  assign dma_read_ready_o = (state_r == S_FILL_DATA);

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      state_r <= S_IDLE;
      beat_r <= '0;
      ex_v_o <= 1'b0;
      for (int s = 0; s < `CACHE_SETS; s++) begin
        tags_r[s] <= '0;
      end
    end else begin
      case (state_r)
        S_IDLE: begin
          if (go && !do_op) begin
            state_r <= (cur_line.valid && cur_line.dirty) ? S_WB_REQ : S_FILL_REQ;
          end
        end
        S_WB_REQ: begin
          if (dma_req_yumi_i) begin
            state_r <= S_WB_DATA;
            beat_r <= '0;
          end
        end
        S_WB_DATA: begin
          if (dma_write_yumi_i) begin
            beat_r <= beat_r + 1'b1;
            if (last_beat) state_r <= S_FILL_REQ;
          end
        end
        S_FILL_REQ: begin
          if (dma_req_yumi_i) begin
            state_r <= S_FILL_DATA;
            beat_r <= '0;
          end
        end
        S_FILL_DATA: begin
          if (dma_read_v_i) begin
            beat_r <= beat_r + 1'b1;
            if (last_beat) begin
              tags_r[cur_a.f.index] <= '{tag: cur_a.f.tag, valid: 1'b1, dirty: 1'b0};
              state_r <= S_DONE;
            end
          end
        end
        S_DONE: if (go) state_r <= S_IDLE;
        default: state_r <= S_IDLE;
      endcase
      if (do_op) begin
        ex_v_o <= 1'b1;
        if (cur_instr == OP_STORE) tags_r[cur_a.f.index].dirty <= 1'b1;
      end else if (ex_ready_i) begin
        ex_v_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (dec_v_i && dec_ready_o) begin
      op_instr_r <= dec_instr_i;
      op_size_r <= dec_size_i;
      op_sigext_r <= dec_sigext_i;
      op_addr_r <= dec_addr_i;
      op_data_r <= dec_data_i;
    end
    if (do_op) begin
      if (cur_instr == OP_LOAD) begin
        ex_word_o <= data_r[cur_a.f.index][cur_a.f.word_off];
        ex_byte_off_o <= cur_a.f.byte_off;
        ex_size_o <= cur_size;
        ex_sigext_o <= cur_sigext;
      end else begin
        ex_word_o <= '0; // stores and no-ops answer zero.
        ex_byte_off_o <= '0;
        ex_size_o <= SZ_WORD;
        ex_sigext_o <= 1'b0;
      end
      if (cur_instr == OP_STORE) data_r[cur_a.f.index][cur_a.f.word_off] <= merged;
    end
    if ((state_r == S_FILL_DATA) && dma_read_v_i) begin
      data_r[cur_a.f.index][beat_r] <= dma_read_data_i;
    end
  end

endmodule

//--- design/op_decode.sv
`timescale 1ns/1ns

module op_decode
  import node_pkg::*;
(
  input clock_i
  ,input rst_i
  ,input v_i
  ,input [PKT_W-1:0] data_i
  ,output logic ready_o
  ,output logic dec_v_o
  ,input dec_ready_i
  ,output instr_e dec_instr_o
  ,output size_e dec_size_o
  ,output logic dec_sigext_o
  ,output logic [ADDR_W-1:0] dec_addr_o
  ,output logic [DATA_W-1:0] dec_data_o
);

  logic up_r;
  logic [SIZE_W-1:0] size_raw;
  size_e size_n;
  logic [ADDR_W-1:0] addr_raw;
  logic [DATA_W-1:0] data_raw;
  logic [ADDR_W-1:0] addr_n;
  logic [DATA_W-1:0] data_n;

  assign size_raw = data_i[SIZE_LSB +: SIZE_W];
  assign addr_raw = data_i[ADDR_LSB +: ADDR_W];
  assign data_raw = data_i[DATA_LSB +: DATA_W];
  assign size_n = (size_raw == 2'd3) ? SZ_WORD : size_e'(size_raw);

  // align the address and move store data into its byte lane.
  always_comb begin
    case (size_n)
      SZ_BYTE: begin
        addr_n = addr_raw;
        data_n = {24'b0, data_raw[7:0]} << {addr_raw[1:0], 3'b000};
      end
      SZ_HALF: begin
        addr_n = {addr_raw[31:1], 1'b0};
        data_n = {16'b0, data_raw[15:0]} << {addr_raw[1], 4'b0000};
      end
      default: begin
        addr_n = {addr_raw[31:2], 2'b00};
        data_n = data_raw;
      end
    endcase
  end

  assign ready_o = up_r && (!dec_v_o || dec_ready_i); // empty or draining.

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      up_r <= 1'b0;
      dec_v_o <= 1'b0;
    end else begin
      up_r <= 1'b1;
      if (v_i && ready_o) begin
        dec_v_o <= 1'b1;
      end else if (dec_ready_i) begin
        dec_v_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (v_i && ready_o) begin
      dec_instr_o <= instr_e'(data_i[INSTR_LSB +: INSTR_W]);
      dec_size_o <= size_n;
      dec_sigext_o <= data_i[SIGEXT_BIT];
      dec_addr_o <= addr_n;
      dec_data_o <= data_n;
    end
  end

endmodule

//--- design/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

  localparam int INDEX_W = $clog2(`CACHE_SETS);
  localparam int WOFF_W = $clog2(`BLOCK_WORDS);
  localparam int BOFF_W = 2;
  localparam int TAG_W = 32 - INDEX_W - WOFF_W - BOFF_W;

  // lookup view of a byte address.
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [INDEX_W-1:0] index;
    logic [WOFF_W-1:0] word_off;
    logic [BOFF_W-1:0] byte_off;
  } cache_addr_s;

  // flat byte address for dma and memory, fields for cache lookup.
  typedef union packed {
    logic [31:0] flat;
    cache_addr_s f;
  } cache_addr_u;

  // one tag array entry.
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic valid;
    logic dirty;
  } line_state_s;

endpackage

//--- design/node_pkg.sv
package node_pkg;

  // command and response packet widths.
  localparam int PKT_W = 80;
  localparam int RESP_PAD_W = 48; // zero bits above the 32-bit result.

  // command field widths.
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int INSTR_W = 4;
  localparam int SIZE_W = 2;

  // command field positions.
  localparam int SIGEXT_BIT = 70;
  localparam int SIZE_LSB = 68;
  localparam int INSTR_LSB = 64;
  localparam int ADDR_LSB = 32;
  localparam int DATA_LSB = 0;

  // any opcode outside these two is a no-op.
  typedef enum logic [INSTR_W-1:0] {
    OP_LOAD = 4'h0,
    OP_STORE = 4'h1
  } instr_e;

  // size 3 on the wire is folded into SZ_WORD by the decoder.
  typedef enum logic [SIZE_W-1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } size_e;

endpackage

//--- design/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// cache geometry.
`define CACHE_SETS 16

// words per line and per dma burst.
`define BLOCK_WORDS 4

// mock memory depth in 32-bit words, byte address wraps at 16 KiB.
`define MEM_WORDS 4096

// idle cycles between request accept and the first beat.
`define MEM_LATENCY 3

// word w of the mock memory starts as this value plus w.
`define MEM_FILL_BASE 32'h1000_0000

`endif
